/* src/mod_pkg.sv */
`default_nettype none

package mod_pkg;

  localparam int IDX_W    = 8;  // 256 samples per segment
  localparam int SAMPLE_W = 8;
  localparam int DATA_W   = 32;
  localparam int DIV_W    = 16;

  // As rep this means loop forever and switch at once
  localparam logic [DATA_W-1:0] REP_INFINITE = {DATA_W{1'b1}};

  typedef enum logic [1:0] {
    OP_WRITE_SAMPLE = 2'd0,  // Segment is addr bit 8, index is addr[7:0]
    OP_SET_CYCLE    = 2'd1,  // Samples in segment addr[0], minus one
    OP_SET_DIV      = 2'd2,  // Clocks per sample of segment addr[0], minus one
    OP_SWAP         = 2'd3   // Requested segment addr[0], rep in data
  } op_t;

endpackage

`default_nettype wire

/* src/mod_settings.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_settings
  import mod_pkg::*;
(
  input  wire logic              CLK,
  input  wire logic              arst_n,
  input  wire logic              req,
  input  wire op_t               op,
  input  wire logic [IDX_W:0]    addr,
  input  wire logic [DATA_W-1:0] data,
  output logic                   ack,
  output logic [IDX_W-1:0]       cycle_0,
  output logic [IDX_W-1:0]       cycle_1,
  output logic [DIV_W-1:0]       div_0,
  output logic [DIV_W-1:0]       div_1,
  output logic                   wr_en,
  output logic                   wr_seg,
  output logic [IDX_W-1:0]       wr_idx,
  output logic [SAMPLE_W-1:0]    wr_sample,
  output logic                   update_settings,
  output logic                   req_rd_segment,
  output logic [DATA_W-1:0]      rep
);

  logic cmd_fire;

  // A command is taken once, on the first edge with req high and ack still low
  assign cmd_fire = req & ~ack;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ack             <= 1'b0;
      wr_en           <= 1'b0;
      update_settings <= 1'b0;
      cycle_0         <= '0;
      cycle_1         <= '0;
      div_0           <= '0;
      div_1           <= '0;
    end else begin
      wr_en           <= 1'b0;
      update_settings <= 1'b0;
      if (cmd_fire) begin
        ack <= 1'b1;
        case (op)
          OP_WRITE_SAMPLE: wr_en <= 1'b1;
          OP_SET_CYCLE: begin
            if (addr[0]) cycle_1 <= data[IDX_W-1:0];
            else cycle_0 <= data[IDX_W-1:0];
          end
          OP_SET_DIV: begin
            if (addr[0]) div_1 <= data[DIV_W-1:0];
            else div_0 <= data[DIV_W-1:0];
          end
          OP_SWAP: update_settings <= 1'b1;
          default: ;
        endcase
      end else if (!req) begin
        ack <= 1'b0;  // Host has released req, close the handshake
      end
    end
  end

  // Values travel alongside the wr_en and update_settings strobes
  always_ff @(posedge CLK) begin
    if (cmd_fire) begin
      wr_seg         <= addr[IDX_W];
      wr_idx         <= addr[IDX_W-1:0];
      wr_sample      <= data[SAMPLE_W-1:0];
      req_rd_segment <= addr[0];
      rep            <= data;
    end
  end

endmodule

`default_nettype wire

/* src/mod_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_timer
  import mod_pkg::*;
(
  input  wire logic             CLK,
  input  wire logic             arst_n,
  input  wire logic [IDX_W-1:0] cycle_0,
  input  wire logic [IDX_W-1:0] cycle_1,
  input  wire logic [DIV_W-1:0] div_0,
  input  wire logic [DIV_W-1:0] div_1,
  output logic      [IDX_W-1:0] idx_0,
  output logic      [IDX_W-1:0] idx_1
);

  logic [IDX_W-1:0] cycle [2];
  logic [DIV_W-1:0] div   [2];
  logic [IDX_W-1:0] idx   [2];

  assign cycle[0] = cycle_0;
  assign cycle[1] = cycle_1;
  assign div[0]   = div_0;
  assign div[1]   = div_1;
  assign idx_0    = idx[0];
  assign idx_1    = idx[1];

  for (genvar s = 0; s < 2; s++) begin : g_seg
    logic [IDX_W-1:0] cycle_q;
    logic [DIV_W-1:0] div_q;
    logic [DIV_W-1:0] div_cnt;
    logic             restart;

    // Any new setting from the host puts this counter back at the start
    assign restart = (cycle[s] != cycle_q) || (div[s] != div_q);

    always_ff @(posedge CLK or negedge arst_n) begin
      if (!arst_n) begin
        cycle_q <= '0;
        div_q   <= '0;
        div_cnt <= '0;
        idx[s]  <= '0;
      end else begin
        cycle_q <= cycle[s];
        div_q   <= div[s];
        if (restart) begin
          div_cnt <= '0;
          idx[s]  <= '0;
        end else if (div_cnt == div_q) begin
          div_cnt <= '0;
          idx[s]  <= (idx[s] == cycle_q) ? '0 : idx[s] + 1'b1;  // Wrap after the last sample
        end else begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/mod_swapchain.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_swapchain
  import mod_pkg::*;
(
  input  wire logic              CLK,
  input  wire logic              arst_n,
  input  wire logic              update_settings,
  input  wire logic              req_rd_segment,
  input  wire logic [DATA_W-1:0] rep,
  input  wire logic [IDX_W-1:0]  idx_0,
  input  wire logic [IDX_W-1:0]  idx_1,
  output logic                   segment,
  output logic                   stop
);

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } state_t;

  state_t            state;
  logic              req_segment;
  logic [DATA_W-1:0] rep_q;
  logic [DATA_W-1:0] loop_cnt;
  logic [IDX_W-1:0]  idx_0_prev;
  logic [IDX_W-1:0]  idx_1_prev;
  logic              wrap_0;
  logic              wrap_1;
  logic              req_idx_zero;
  logic              cur_wrap;

  // A wrap is an index that just moved and landed on zero
  assign wrap_0 = (idx_0 != idx_0_prev) && (idx_0 == '0);
  assign wrap_1 = (idx_1 != idx_1_prev) && (idx_1 == '0);

  assign req_idx_zero = req_segment ? (idx_1 == '0) : (idx_0 == '0);
  assign cur_wrap     = segment ? wrap_1 : wrap_0;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      idx_0_prev <= '0;
      idx_1_prev <= '0;
    end else begin
      idx_0_prev <= idx_0;
      idx_1_prev <= idx_1;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state       <= INFINITE_LOOP;
      segment     <= 1'b0;
      stop        <= 1'b0;
      req_segment <= 1'b0;
      rep_q       <= '0;
      loop_cnt    <= '0;
    end else if (update_settings) begin
      if (req_rd_segment == segment) begin
        stop  <= 1'b0;  // Same segment just resumes forever
        state <= INFINITE_LOOP;
      end else if (rep == REP_INFINITE) begin
        stop    <= 1'b0;
        segment <= req_rd_segment;
        state   <= INFINITE_LOOP;
      end else begin
        rep_q       <= rep;
        req_segment <= req_rd_segment;
        state       <= WAIT_START;
      end
    end else begin
      case (state)
        WAIT_START: begin
          // Old segment keeps playing until the new one is at its start
          if (req_idx_zero) begin
            stop     <= 1'b0;
            loop_cnt <= '0;
            segment  <= req_segment;
            state    <= FINITE_LOOP;
          end
        end
        FINITE_LOOP: begin
          if (cur_wrap && !stop) begin
            if (loop_cnt == rep_q) stop <= 1'b1;  // End of loop rep+1
            else loop_cnt <= loop_cnt + 1'b1;
          end
        end
        INFINITE_LOOP: ;
        default: state <= INFINITE_LOOP;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/mod_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_memory
  import mod_pkg::*;
(
  input  wire logic                CLK,
  input  wire logic                arst_n,
  input  wire logic                wr_en,
  input  wire logic                wr_seg,
  input  wire logic [IDX_W-1:0]    wr_idx,
  input  wire logic [SAMPLE_W-1:0] wr_sample,
  input  wire logic [IDX_W-1:0]    idx_0,
  input  wire logic [IDX_W-1:0]    idx_1,
  input  wire logic                segment,
  input  wire logic                stop,
  output logic      [SAMPLE_W-1:0] sample,
  output logic      [IDX_W-1:0]    sample_idx
);

  // Segment number is the top address bit
  logic [SAMPLE_W-1:0] mem [2**(IDX_W+1)];
  logic [IDX_W-1:0]    rd_idx;

  assign rd_idx = segment ? idx_1 : idx_0;

  always_ff @(posedge CLK) begin
    if (wr_en) mem[{wr_seg, wr_idx}] <= wr_sample;
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sample     <= '0;
      sample_idx <= '0;
    end else begin
      sample     <= stop ? '0 : mem[{segment, rd_idx}];  // Stopped stream is silent
      sample_idx <= rd_idx;
    end
  end

endmodule

`default_nettype wire

/* src/mod_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_top
  import mod_pkg::*;
(
  input  wire logic                CLK,
  input  wire logic                arst_n,
  input  wire logic                req,
  input  wire op_t                 op,
  input  wire logic [IDX_W:0]      addr,
  input  wire logic [DATA_W-1:0]   data,
  output logic                     ack,
  output logic      [SAMPLE_W-1:0] sample,
  output logic      [IDX_W-1:0]    sample_idx,
  output logic                     segment,
  output logic                     stop
);

  logic [IDX_W-1:0]    cycle_0;
  logic [IDX_W-1:0]    cycle_1;
  logic [DIV_W-1:0]    div_0;
  logic [DIV_W-1:0]    div_1;
  logic                wr_en;
  logic                wr_seg;
  logic [IDX_W-1:0]    wr_idx;
  logic [SAMPLE_W-1:0] wr_sample;
  logic                update_settings;
  logic                req_rd_segment;
  logic [DATA_W-1:0]   rep;
  logic [IDX_W-1:0]    idx_0;
  logic [IDX_W-1:0]    idx_1;

  mod_settings u_settings (
    .CLK, .arst_n, .req, .op, .addr, .data, .ack,
    .cycle_0, .cycle_1, .div_0, .div_1,
    .wr_en, .wr_seg, .wr_idx, .wr_sample,
    .update_settings, .req_rd_segment, .rep
  );

  mod_timer u_timer (
    .CLK, .arst_n, .cycle_0, .cycle_1, .div_0, .div_1, .idx_0, .idx_1
  );

  mod_swapchain u_swapchain (
    .CLK, .arst_n, .update_settings, .req_rd_segment, .rep,
    .idx_0, .idx_1, .segment, .stop
  );

  mod_memory u_memory (
    .CLK, .arst_n, .wr_en, .wr_seg, .wr_idx, .wr_sample,
    .idx_0, .idx_1, .segment, .stop, .sample, .sample_idx
  );

endmodule

`default_nettype wire

/* testbench/mod_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_properties (
  input wire logic CLK,
  input wire logic arst_n,
  input wire logic req,
  input wire logic ack,
  input wire logic update_settings,
  input wire logic stop,
  input wire logic in_finite
);

  a_ack_after_req: assert property (@(posedge CLK) disable iff (!arst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose while req was low");

  a_update_one_clock: assert property (@(posedge CLK) disable iff (!arst_n)
    update_settings |=> !update_settings)
    else $error("update_settings held for more than one clock");

  // Stop is only set by the loop counter of the finite state
  a_stop_in_finite: assert property (@(posedge CLK) disable iff (!arst_n)
    $rose(stop) |-> $past(in_finite))
    else $error("stop rose outside finite looping");

endmodule

bind mod_settings mod_properties u_settings_props (
  .CLK, .arst_n, .req, .ack, .update_settings, .stop(1'b0), .in_finite(1'b0)
);

bind mod_swapchain mod_properties u_swapchain_props (
  .CLK, .arst_n, .req(1'b0), .ack(1'b0), .update_settings, .stop,
  .in_finite(state == FINITE_LOOP)
);

`default_nettype wire

/* testbench/mod_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_tb
  import mod_pkg::*;
();

  typedef enum {S_WAIT, S_FINITE, S_INFINITE} swap_t;

  localparam int TIMEOUT = 2000;  // Clocks allowed for any single wait

  logic CLK, arst_n, req, ack, segment, stop;
  op_t op;
  logic [IDX_W:0] addr;
  logic [DATA_W-1:0] data;
  logic [SAMPLE_W-1:0] sample;
  logic [IDX_W-1:0] sample_idx;

  logic [31:0] rng = 32'd77;
  int tests, checks, errors, errs_before;
  logic checking;

  // Reference model state
  logic [SAMPLE_W-1:0] m_mem [2][2**IDX_W];
  logic [IDX_W-1:0] m_cycle [2], m_idx [2], m_prev [2];
  logic [DIV_W-1:0] m_div [2], m_cnt [2];
  logic m_restart [2];
  logic m_ack, m_upd, m_req_seg, m_wait_seg, m_seg, m_stop;
  logic [DATA_W-1:0] m_rep, m_wait_rep, m_loop;
  swap_t m_state;
  logic [SAMPLE_W-1:0] m_sample;
  logic [IDX_W-1:0] m_sample_idx;

  mod_top DUT (
    .CLK, .arst_n, .req, .op, .addr, .data, .ack,
    .sample, .sample_idx, .segment, .stop
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  always @(posedge CLK or negedge arst_n) begin
    logic cur_wrap;
    if (!arst_n) begin
      m_ack = 1'b0;
      m_upd = 1'b0;
      m_seg = 1'b0;
      m_stop = 1'b0;
      m_loop = '0;
      m_state = S_INFINITE;
      m_sample = '0;
      m_sample_idx = '0;
      for (int s = 0; s < 2; s++) begin
        m_cycle[s] = '0;
        m_div[s] = '0;
        m_cnt[s] = '0;
        m_idx[s] = '0;
        m_prev[s] = '0;
        m_restart[s] = 1'b0;
      end
    end else begin
      // Output stage sees the indices and flags from before this edge
      m_sample = m_stop ? '0 : m_mem[m_seg][m_idx[m_seg]];
      m_sample_idx = m_idx[m_seg];
      cur_wrap = (m_idx[m_seg] != m_prev[m_seg]) && (m_idx[m_seg] == '0);
      if (m_upd) begin
        m_upd = 1'b0;
        if (m_req_seg == m_seg) begin
          m_stop = 1'b0;
          m_state = S_INFINITE;
        end else if (m_rep == REP_INFINITE) begin
          m_stop = 1'b0;
          m_seg = m_req_seg;
          m_state = S_INFINITE;
        end else begin
          m_wait_seg = m_req_seg;
          m_wait_rep = m_rep;
          m_state = S_WAIT;
        end
      end else if (m_state == S_WAIT && m_idx[m_wait_seg] == '0) begin
        m_stop = 1'b0;
        m_loop = '0;
        m_seg = m_wait_seg;
        m_state = S_FINITE;
      end else if (m_state == S_FINITE && cur_wrap && !m_stop) begin
        if (m_loop == m_wait_rep) m_stop = 1'b1;  // Wrap that ends loop rep+1
        else m_loop++;
      end
      for (int s = 0; s < 2; s++) begin
        m_prev[s] = m_idx[s];
        if (m_restart[s]) begin
          m_idx[s] = '0;
          m_cnt[s] = '0;
          m_restart[s] = 1'b0;
        end else if (m_cnt[s] == m_div[s]) begin
          m_cnt[s] = '0;
          m_idx[s] = (m_idx[s] == m_cycle[s]) ? '0 : m_idx[s] + 1'b1;
        end else begin
          m_cnt[s]++;
        end
      end
      if (req && !m_ack) begin
        m_ack = 1'b1;
        case (op)
          OP_WRITE_SAMPLE: m_mem[addr[IDX_W]][addr[IDX_W-1:0]] = data[SAMPLE_W-1:0];
          OP_SET_CYCLE: begin
            m_restart[addr[0]] |= (m_cycle[addr[0]] != data[IDX_W-1:0]);
            m_cycle[addr[0]] = data[IDX_W-1:0];
          end
          OP_SET_DIV: begin
            m_restart[addr[0]] |= (m_div[addr[0]] != data[DIV_W-1:0]);
            m_div[addr[0]] = data[DIV_W-1:0];
          end
          default: begin
            m_upd = 1'b1;  // Swap reaches the swapchain one clock later
            m_req_seg = addr[0];
            m_rep = data;
          end
        endcase
      end else if (!req) begin
        m_ack = 1'b0;
      end
    end
  end

  task automatic check_sample(input string what, input logic [SAMPLE_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_idx(input string what, input logic [IDX_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Outputs settle after the rising edge, so compare on the falling one
  always @(negedge CLK) begin
    if (checking) begin
      check_sample("sample", sample, m_sample);
      check_idx("sample_idx", sample_idx, m_sample_idx);
      check_flag("segment", segment, m_seg);
      check_flag("stop", stop, m_stop);
      check_flag("ack", ack, m_ack);
    end
  end

  task automatic send_cmd(input op_t o, input logic [IDX_W:0] a, input logic [DATA_W-1:0] d);
    int t;
    @(posedge CLK);
    #2;
    req = 1'b1;
    op = o;
    addr = a;
    data = d;
    t = 0;
    while (!ack && t < TIMEOUT) begin
      @(posedge CLK);
      #2;
      t++;
    end
    if (!ack) begin
      $display("ERROR at %0t ns: ack never rose for %s", $time, o.name());
      errors++;
    end
    req = 1'b0;
    t = 0;
    while (ack && t < TIMEOUT) begin
      @(posedge CLK);
      #2;
      t++;
    end
    if (ack) begin
      $display("ERROR at %0t ns: ack stayed high after req dropped", $time);
      errors++;
    end
  endtask

  task automatic wait_wraps(input int n);
    int t;
    int seen;
    logic [IDX_W-1:0] last;
    t = 0;
    seen = 0;
    last = m_idx[m_seg];
    while (seen < n && t < TIMEOUT) begin
      @(posedge CLK);
      #2;
      if (m_idx[m_seg] == '0 && last != '0) seen++;
      last = m_idx[m_seg];
      t++;
    end
    if (seen < n) begin
      $display("ERROR at %0t ns: active segment index did not wrap in time", $time);
      errors++;
    end
  endtask

  task automatic wait_stop();
    int t;
    t = 0;
    while (stop !== 1'b1 && t < TIMEOUT) begin
      @(posedge CLK);
      #2;
      t++;
    end
    if (stop !== 1'b1) begin
      $display("ERROR at %0t ns: stop never rose after the finite swap", $time);
      errors++;
    end
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %-14s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    errs_before = errors;
  endtask

  initial begin
    tests = 0;
    checks = 0;
    errors = 0;
    errs_before = 0;
    checking = 1'b0;
    arst_n = 1'b0;
    req = 1'b0;
    op = OP_WRITE_SAMPLE;
    addr = '0;
    data = '0;
    repeat (2) @(posedge CLK);
    #2;
    arst_n = 1'b1;

    // Cycles stay below 16, so only the first 16 samples of a segment play
    for (int i = 0; i < 32; i++) send_cmd(OP_WRITE_SAMPLE, i[IDX_W:0] + (i / 16) * 240, next_rand());
    checking = 1'b1;
    for (int s = 0; s < 2; s++) begin
      send_cmd(OP_SET_CYCLE, s, 1 + next_rand() % 15);
      send_cmd(OP_SET_DIV, s, next_rand() % 4);
    end
    report_test("handshake");

    wait_wraps(3);
    report_test("playback");

    send_cmd(OP_SWAP, 1, REP_INFINITE);
    check_flag("segment after infinite swap", segment, 1'b1);
    wait_wraps(2);
    report_test("infinite_swap");

    send_cmd(OP_SWAP, 0, next_rand() % 4);
    wait_stop();
    wait_wraps(1);
    check_flag("stop after finite swap", stop, 1'b1);
    check_sample("sample after stop", sample, '0);
    report_test("finite_swap");

    send_cmd(OP_SWAP, 0, '0);
    check_flag("stop after same-segment swap", stop, 1'b0);
    wait_wraps(2);
    report_test("same_swap");

    $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mod_subsys.f */
src/mod_pkg.sv
src/mod_settings.sv
src/mod_timer.sv
src/mod_swapchain.sv
src/mod_memory.sv
src/mod_top.sv
testbench/mod_properties.sv
testbench/mod_tb.sv

/* Bender.yml */
package:
  name: mod_subsys

sources:
  - files:
      - src/mod_pkg.sv
      - src/mod_settings.sv
      - src/mod_timer.sv
      - src/mod_swapchain.sv
      - src/mod_memory.sv
      - src/mod_top.sv
  - target: test
    files:
      - testbench/mod_properties.sv
      - testbench/mod_tb.sv
